// ==== exe_pkg.sv ====
package exe_pkg;

    ////////////////////
    // widths
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;
    localparam int IMM_W    = 16;
    localparam int JADDR_W  = 26;
    localparam int CODE_W   = 6;   // opcode and funct

    localparam int SP_IDX   = 29;
    localparam int LINK_IDX = 31;  // jal link

    ////////////////////
    // opcodes
    localparam logic [CODE_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [CODE_W-1:0] OP_J     = 6'h02;
    localparam logic [CODE_W-1:0] OP_JAL   = 6'h03;
    localparam logic [CODE_W-1:0] OP_BEQ   = 6'h04;
    localparam logic [CODE_W-1:0] OP_BNE   = 6'h05;
    localparam logic [CODE_W-1:0] OP_ADDI  = 6'h08;
    localparam logic [CODE_W-1:0] OP_ADDIU = 6'h09;
    localparam logic [CODE_W-1:0] OP_SLTI  = 6'h0a;
    localparam logic [CODE_W-1:0] OP_SLTIU = 6'h0b;
    localparam logic [CODE_W-1:0] OP_ANDI  = 6'h0c;
    localparam logic [CODE_W-1:0] OP_ORI   = 6'h0d;
    localparam logic [CODE_W-1:0] OP_XORI  = 6'h0e;
    localparam logic [CODE_W-1:0] OP_LUI   = 6'h0f;
    localparam logic [CODE_W-1:0] OP_LW    = 6'h23;
    localparam logic [CODE_W-1:0] OP_SW    = 6'h2b;

    ////////////////////
    // funct codes
    localparam logic [CODE_W-1:0] FN_SLL  = 6'h00;
    localparam logic [CODE_W-1:0] FN_SRL  = 6'h02;
    localparam logic [CODE_W-1:0] FN_SRA  = 6'h03;
    localparam logic [CODE_W-1:0] FN_SLLV = 6'h04;
    localparam logic [CODE_W-1:0] FN_SRLV = 6'h06;
    localparam logic [CODE_W-1:0] FN_SRAV = 6'h07;
    localparam logic [CODE_W-1:0] FN_JR   = 6'h08;
    localparam logic [CODE_W-1:0] FN_ADD  = 6'h20;
    localparam logic [CODE_W-1:0] FN_ADDU = 6'h21;
    localparam logic [CODE_W-1:0] FN_SUB  = 6'h22;
    localparam logic [CODE_W-1:0] FN_SUBU = 6'h23;
    localparam logic [CODE_W-1:0] FN_AND  = 6'h24;
    localparam logic [CODE_W-1:0] FN_OR   = 6'h25;
    localparam logic [CODE_W-1:0] FN_XOR  = 6'h26;
    localparam logic [CODE_W-1:0] FN_NOR  = 6'h27;
    localparam logic [CODE_W-1:0] FN_SLT  = 6'h2a;
    localparam logic [CODE_W-1:0] FN_SLTU = 6'h2b;

    typedef logic [REG_AW-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]   word_t;

    localparam word_t SP_RESET = 32'h0000_3fff;

    typedef struct packed {
        logic [CODE_W-1:0] opcode;
        reg_idx_t          rs;
        reg_idx_t          rt;
        reg_idx_t          rd;
        logic [REG_AW-1:0] shamt;
        logic [CODE_W-1:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [CODE_W-1:0] opcode;
        reg_idx_t          rs;
        reg_idx_t          rt;
        logic [IMM_W-1:0]  imm;
    } instr_i_t;

    typedef struct packed {
        logic [CODE_W-1:0]  opcode;
        logic [JADDR_W-1:0] target;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

endpackage

// ==== exe_if.sv ====
// operand read port, indices out, data back the same cycle
interface rd_if;
    exe_pkg::reg_idx_t rs_idx;
    exe_pkg::reg_idx_t rt_idx;
    exe_pkg::word_t    rs_data;
    exe_pkg::word_t    rt_data;

    modport alu (
        output rs_idx,
        output rt_idx,
        input  rs_data,
        input  rt_data
    );

    modport rf (
        input  rs_idx,
        input  rt_idx,
        output rs_data,
        output rt_data
    );
endinterface

interface wr_if;
    logic              wr_en;
    exe_pkg::reg_idx_t wr_idx;
    exe_pkg::word_t    wr_data;

    modport arbiter (
        output wr_en,
        output wr_idx,
        output wr_data
    );

    modport rf (
        input  wr_en,
        input  wr_idx,
        input  wr_data
    );
endinterface

// ==== exe_alu.sv ====
module exe_alu (
    input  logic                         instr_valid_i,
    input  exe_pkg::instr_u              instr_i,
    input  exe_pkg::word_t               pc_plus4_i,
    rd_if.alu                            rd,
    output logic                         alu_wr_en_o,
    output exe_pkg::reg_idx_t            alu_wr_idx_o,
    output exe_pkg::word_t               alu_wr_data_o,
    output logic                         is_lw_o,
    output logic                         is_sw_o,
    output logic                         is_beq_o,
    output logic                         is_bne_o,
    output logic                         is_jump_o,
    output logic [exe_pkg::JADDR_W-1:0]  jump_target_o,
    output exe_pkg::word_t               mem_addr_o,
    output exe_pkg::word_t               store_data_o,
    output logic                         rs_eq_rt_o,
    output logic [exe_pkg::IMM_W-1:0]    branch_off_o
);
    import exe_pkg::*;

    word_t rs_val;
    word_t rt_val;
    word_t imm_zx;
    word_t imm_sx;
    logic  is_rtype;
    logic  is_jr;
    logic  wr_en;

    assign rd.rs_idx = instr_i.r.rs;
    assign rd.rt_idx = instr_i.r.rt;
    assign rs_val    = rd.rs_data;
    assign rt_val    = rd.rt_data;

    assign imm_zx = {{(XLEN-IMM_W){1'b0}}, instr_i.i.imm};
    assign imm_sx = {{(XLEN-IMM_W){instr_i.i.imm[IMM_W-1]}}, instr_i.i.imm};

    assign is_rtype = (instr_i.r.opcode == OP_RTYPE);
    assign is_jr    = is_rtype && (instr_i.r.funct == FN_JR);

    always_comb begin
        wr_en         = 1'b0;
        alu_wr_idx_o  = instr_i.i.rt;  // lw target also travels here
        alu_wr_data_o = '0;
        if (is_rtype) begin
            alu_wr_idx_o = instr_i.r.rd;
            wr_en        = 1'b1;
            case (instr_i.r.funct)
                FN_SLL:          alu_wr_data_o = rt_val << instr_i.r.shamt;
                FN_SRL:          alu_wr_data_o = rt_val >> instr_i.r.shamt;
                FN_SRA:          alu_wr_data_o = $signed(rt_val) >>> instr_i.r.shamt;
                FN_SLLV:         alu_wr_data_o = rt_val << rs_val[REG_AW-1:0];
                FN_SRLV:         alu_wr_data_o = rt_val >> rs_val[REG_AW-1:0];
                FN_SRAV:         alu_wr_data_o = $signed(rt_val) >>> rs_val[REG_AW-1:0];
                FN_ADD, FN_ADDU: alu_wr_data_o = rs_val + rt_val;
                FN_SUB, FN_SUBU: alu_wr_data_o = rs_val - rt_val;
                FN_AND:          alu_wr_data_o = rs_val & rt_val;
                FN_OR:           alu_wr_data_o = rs_val | rt_val;
                FN_XOR:          alu_wr_data_o = rs_val ^ rt_val;
                FN_NOR:          alu_wr_data_o = ~(rs_val | rt_val);
                FN_SLT:          alu_wr_data_o = word_t'($signed(rs_val) < $signed(rt_val));
                FN_SLTU:         alu_wr_data_o = word_t'(rs_val < rt_val);
                default:         wr_en = 1'b0;  // jr and unknown funct
            endcase
        end else begin
            wr_en = 1'b1;
            case (instr_i.i.opcode)
                OP_ADDI, OP_ADDIU: alu_wr_data_o = rs_val + imm_zx;
                OP_SLTI:  alu_wr_data_o = word_t'($signed(rs_val) < $signed(imm_sx));
                OP_SLTIU: alu_wr_data_o = word_t'(rs_val < imm_zx);
                OP_ANDI:  alu_wr_data_o = rs_val & imm_zx;
                OP_ORI:   alu_wr_data_o = rs_val | imm_zx;
                OP_XORI:  alu_wr_data_o = rs_val ^ imm_zx;
                OP_LUI:   alu_wr_data_o = {instr_i.i.imm, {(XLEN-IMM_W){1'b0}}};
                OP_JAL: begin
                    alu_wr_idx_o  = reg_idx_t'(LINK_IDX);
                    alu_wr_data_o = pc_plus4_i;
                end
                default:  wr_en = 1'b0;  // lw, sw, branches, j
            endcase
        end
    end

    assign alu_wr_en_o = instr_valid_i && wr_en;

    ////////////////////
    // class strobes
    assign is_lw_o   = instr_valid_i && (instr_i.i.opcode == OP_LW);
    assign is_sw_o   = instr_valid_i && (instr_i.i.opcode == OP_SW);
    assign is_beq_o  = instr_valid_i && (instr_i.i.opcode == OP_BEQ);
    assign is_bne_o  = instr_valid_i && (instr_i.i.opcode == OP_BNE);
    assign is_jump_o = instr_valid_i
                       && (is_jr || instr_i.j.opcode == OP_J || instr_i.j.opcode == OP_JAL);

    assign jump_target_o = is_jr ? rs_val[JADDR_W-1:0] : instr_i.j.target;
    assign mem_addr_o    = rs_val + imm_zx;  // zero-extended offset
    assign store_data_o  = rt_val;
    assign rs_eq_rt_o    = (rs_val == rt_val);
    assign branch_off_o  = instr_i.i.imm;

endmodule

// ==== exe_regfile.sv ====
module exe_regfile (
    input  logic clk_i,
    input  logic arst_n_i,
    rd_if.rf     rd,
    wr_if.rf     wr
);
    import exe_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= (k == SP_IDX) ? SP_RESET : '0;  // sp starts at top
            end
        end else if (wr.wr_en && (wr.wr_idx != '0)) begin
            regs[wr.wr_idx] <= wr.wr_data;
        end
    end

    // r0 hardwired
    assign rd.rs_data = (rd.rs_idx == '0) ? '0 : regs[rd.rs_idx];
    assign rd.rt_data = (rd.rt_idx == '0) ? '0 : regs[rd.rt_idx];

endmodule

// ==== exe_mem_branch.sv ====
module exe_mem_branch (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  exe_pkg::word_t               data_load_i,
    input  logic                         alu_wr_en_i,
    input  exe_pkg::reg_idx_t            alu_wr_idx_i,
    input  exe_pkg::word_t               alu_wr_data_i,
    input  logic                         is_lw_i,
    input  logic                         is_sw_i,
    input  logic                         is_beq_i,
    input  logic                         is_bne_i,
    input  logic                         is_jump_i,
    input  logic [exe_pkg::JADDR_W-1:0]  jump_target_i,
    input  exe_pkg::word_t               mem_addr_i,
    input  exe_pkg::word_t               store_data_i,
    input  logic                         rs_eq_rt_i,
    input  logic [exe_pkg::IMM_W-1:0]    branch_off_i,
    wr_if.arbiter                        wr,
    output exe_pkg::word_t               data_addr_o,
    output logic                         data_wen_o,
    output exe_pkg::word_t               data_store_o,
    output logic                         j_valid_o,
    output logic [exe_pkg::JADDR_W-1:0]  j_addr_o,
    output logic                         b_valid_o,
    output logic [exe_pkg::IMM_W-1:0]    b_addr_o
);
    import exe_pkg::*;

    reg_idx_t ld_idx_q;  // zero means no load pending
    logic     ld_wr;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ld_idx_q   <= '0;
            j_valid_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            data_wen_o <= 1'b0;
        end else begin
            ld_idx_q   <= is_lw_i ? alu_wr_idx_i : '0;
            j_valid_o  <= is_jump_i;
            b_valid_o  <= (is_beq_i && rs_eq_rt_i) || (is_bne_i && !rs_eq_rt_i);
            data_wen_o <= is_sw_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_jump_i) begin
            j_addr_o <= jump_target_i;
        end
        if (is_beq_i || is_bne_i) begin
            b_addr_o <= branch_off_i;
        end
        if (is_lw_i || is_sw_i) begin
            data_addr_o <= mem_addr_i;
        end
        if (is_sw_i) begin
            data_store_o <= store_data_i;
        end
    end

    ////////////////////
    // write port, load wins
    assign ld_wr = (ld_idx_q != '0);

    assign wr.wr_en   = ld_wr || alu_wr_en_i;
    assign wr.wr_idx  = ld_wr ? ld_idx_q : alu_wr_idx_i;
    assign wr.wr_data = ld_wr ? data_load_i : alu_wr_data_i;  // alu result dropped

endmodule

// ==== exe_top.sv ====
module exe_top (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         instr_valid_i,
    input  exe_pkg::word_t               instr_i,
    input  exe_pkg::word_t               pc_plus4_i,
    input  exe_pkg::word_t               data_load_i,
    output exe_pkg::word_t               data_addr_o,
    output logic                         data_wen_o,
    output exe_pkg::word_t               data_store_o,
    output logic                         j_valid_o,
    output logic [exe_pkg::JADDR_W-1:0]  j_addr_o,
    output logic                         b_valid_o,
    output logic [exe_pkg::IMM_W-1:0]    b_addr_o
);
    import exe_pkg::*;

    logic               alu_wr_en;
    reg_idx_t           alu_wr_idx;
    word_t              alu_wr_data;
    logic               is_lw;
    logic               is_sw;
    logic               is_beq;
    logic               is_bne;
    logic               is_jump;
    logic [JADDR_W-1:0] jump_target;
    word_t              mem_addr;
    word_t              store_data;
    logic               rs_eq_rt;
    logic [IMM_W-1:0]   branch_off;

    rd_if rd_bus ();
    wr_if wr_bus ();

    exe_alu i_alu (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_plus4_i    (pc_plus4_i),
        .rd            (rd_bus),
        .alu_wr_en_o   (alu_wr_en),
        .alu_wr_idx_o  (alu_wr_idx),
        .alu_wr_data_o (alu_wr_data),
        .is_lw_o       (is_lw),
        .is_sw_o       (is_sw),
        .is_beq_o      (is_beq),
        .is_bne_o      (is_bne),
        .is_jump_o     (is_jump),
        .jump_target_o (jump_target),
        .mem_addr_o    (mem_addr),
        .store_data_o  (store_data),
        .rs_eq_rt_o    (rs_eq_rt),
        .branch_off_o  (branch_off)
    );

    exe_regfile i_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rd       (rd_bus),
        .wr       (wr_bus)
    );

    exe_mem_branch i_mem_branch (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .data_load_i   (data_load_i),
        .alu_wr_en_i   (alu_wr_en),
        .alu_wr_idx_i  (alu_wr_idx),
        .alu_wr_data_i (alu_wr_data),
        .is_lw_i       (is_lw),
        .is_sw_i       (is_sw),
        .is_beq_i      (is_beq),
        .is_bne_i      (is_bne),
        .is_jump_i     (is_jump),
        .jump_target_i (jump_target),
        .mem_addr_i    (mem_addr),
        .store_data_i  (store_data),
        .rs_eq_rt_i    (rs_eq_rt),
        .branch_off_i  (branch_off),
        .wr            (wr_bus),
        .data_addr_o   (data_addr_o),
        .data_wen_o    (data_wen_o),
        .data_store_o  (data_store_o),
        .j_valid_o     (j_valid_o),
        .j_addr_o      (j_addr_o),
        .b_valid_o     (b_valid_o),
        .b_addr_o      (b_addr_o)
    );

endmodule

// ==== tb_exe_tasks.svh ====
`ifndef TB_EXE_TASKS_SVH
`define TB_EXE_TASKS_SVH

////////////////////
// encoders
function automatic word_t r_instr(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                                  input logic [4:0] shamt, input logic [5:0] funct);
    return {OP_RTYPE, rs, rt, rd, shamt, funct};
endfunction

function automatic word_t i_instr(input logic [5:0] op, input reg_idx_t rs, input reg_idx_t rt,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t j_instr(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
endfunction

////////////////////
// drive and check
task automatic check_word(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
        err_count++;
        $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic drive_instr(input word_t word);
    instr       = word;
    instr_valid = 1'b1;
    @(posedge clk);
    #(DRIVE_DLY);             // registered outputs of word now visible
    instr_valid = 1'b0;
endtask

task automatic idle_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
endtask

task automatic load_reg(input reg_idx_t idx, input word_t value);
    drive_instr(i_instr(OP_LUI, 5'd0, idx, value[31:16]));
    drive_instr(i_instr(OP_ORI, idx, idx, value[15:0]));
endtask

// sw from base r0 puts the register on the store port
task automatic check_reg(input reg_idx_t idx, input word_t exp, input string what);
    drive_instr(i_instr(OP_SW, 5'd0, idx, {11'd0, idx}));
    check_word(data_store, exp, what);
    check_word(data_addr, {27'd0, idx}, {what, " store address"});
endtask

task automatic check_i_op(input logic [5:0] op, input logic [15:0] imm, input word_t exp,
                          input string what);
    drive_instr(i_instr(op, 5'd1, 5'd2, imm));
    check_reg(5'd2, exp, what);
endtask

task automatic check_r_op(input logic [5:0] funct, input reg_idx_t rs, input logic [4:0] shamt,
                          input word_t exp, input string what);
    drive_instr(r_instr(rs, 5'd2, 5'd4, shamt, funct));
    check_reg(5'd4, exp, what);
endtask

task automatic check_branch(input logic [5:0] op, input reg_idx_t rt, input logic [15:0] off,
                            input logic taken, input string what);
    drive_instr(i_instr(op, 5'd1, rt, off));
    check_word(word_t'(b_valid), taken ? 32'd1 : 32'd0, {what, " b_valid"});
    if (taken) begin
        check_word(word_t'(b_addr), {16'd0, off}, {what, " b_addr"});
    end
    check_word(word_t'(j_valid), 32'd0, {what, " j_valid"});
    idle_cycle();
    check_word(word_t'(b_valid), 32'd0, {what, " b_valid pulse width"});
endtask

task automatic check_jump(input logic [25:0] target, input string what);
    check_word(word_t'(j_valid), 32'd1, {what, " j_valid"});
    check_word(word_t'(j_addr), {6'd0, target}, {what, " j_addr"});
    idle_cycle();
    check_word(word_t'(j_valid), 32'd0, {what, " j_valid pulse width"});
endtask

task automatic report_test(input string name, input int err_start);
    test_count++;
    $display("test %s: %0d mismatches", name, err_count - err_start);
endtask

////////////////////
// tests
task automatic reset_test();
    int err_start;
    err_start = err_count;
    check_word(word_t'(j_valid), 32'd0, "j_valid after reset");
    check_word(word_t'(b_valid), 32'd0, "b_valid after reset");
    check_word(word_t'(data_wen), 32'd0, "data_wen after reset");
    check_reg(5'd0, 32'd0, "r0 after reset");
    check_reg(5'd29, 32'h0000_3fff, "r29 after reset");
    check_reg(5'd5, 32'd0, "r5 after reset");
    report_test("reset_state", err_start);
endtask

task automatic i_format_test();
    word_t       a;
    logic [15:0] imm;
    word_t       zx;
    word_t       sx;
    int          err_start;
    err_start = err_count;
    for (int it = 0; it < 4; it++) begin
        if (it == 0) begin
            a   = 32'hffff_8001;  // slti and sltiu disagree here
            imm = 16'hfff0;
        end else begin
            a   = $urandom();
            imm = 16'($urandom());
        end
        zx = {16'd0, imm};
        sx = {{16{imm[15]}}, imm};
        load_reg(5'd1, a);
        check_i_op(OP_ADDI, imm, a + zx, "addi");
        check_i_op(OP_ADDIU, imm, a + zx, "addiu");
        check_i_op(OP_SLTI, imm, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0, "slti");
        check_i_op(OP_SLTIU, imm, (a < zx) ? 32'd1 : 32'd0, "sltiu");
        check_i_op(OP_ANDI, imm, a & zx, "andi");
        check_i_op(OP_ORI, imm, a | zx, "ori");
        check_i_op(OP_XORI, imm, a ^ zx, "xori");
        check_i_op(OP_LUI, imm, {imm, 16'd0}, "lui");
    end
    drive_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'h1234));
    check_reg(5'd0, 32'd0, "r0 after addi");
    report_test("i_format", err_start);
endtask

task automatic r_format_test();
    word_t      a;
    word_t      b;
    word_t      c;
    logic [4:0] sh;
    int         err_start;
    err_start = err_count;
    for (int it = 0; it < 3; it++) begin
        if (it == 0) begin
            a = 32'h8000_0001;
            b = 32'h0000_0005;
            c = 32'hffff_ffe4;    // upper bits must not affect variable shifts
        end else begin
            a = $urandom();
            b = $urandom();
            c = $urandom();
        end
        sh = 5'($urandom());
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        load_reg(5'd3, c);
        check_r_op(FN_SLL, 5'd0, sh, b << sh, "sll");
        check_r_op(FN_SRL, 5'd0, sh, b >> sh, "srl");
        check_r_op(FN_SRA, 5'd0, sh, $signed(b) >>> sh, "sra");
        check_r_op(FN_SLLV, 5'd3, 5'd0, b << c[4:0], "sllv");
        check_r_op(FN_SRLV, 5'd3, 5'd0, b >> c[4:0], "srlv");
        check_r_op(FN_SRAV, 5'd3, 5'd0, $signed(b) >>> c[4:0], "srav");
        check_r_op(FN_ADD, 5'd1, 5'd0, a + b, "add");
        check_r_op(FN_ADDU, 5'd1, 5'd0, a + b, "addu");
        check_r_op(FN_SUB, 5'd1, 5'd0, a - b, "sub");
        check_r_op(FN_SUBU, 5'd1, 5'd0, a - b, "subu");
        check_r_op(FN_AND, 5'd1, 5'd0, a & b, "and");
        check_r_op(FN_OR, 5'd1, 5'd0, a | b, "or");
        check_r_op(FN_XOR, 5'd1, 5'd0, a ^ b, "xor");
        check_r_op(FN_NOR, 5'd1, 5'd0, ~(a | b), "nor");
        check_r_op(FN_SLT, 5'd1, 5'd0, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "slt");
        check_r_op(FN_SLTU, 5'd1, 5'd0, (a < b) ? 32'd1 : 32'd0, "sltu");
    end
    drive_instr(r_instr(5'd1, 5'd2, 5'd5, 5'd0, FN_ADD));
    drive_instr(r_instr(5'd5, 5'd1, 5'd6, 5'd0, FN_SUB));  // reads r5 written one edge ago
    check_reg(5'd6, b, "dependent add then sub");
    report_test("r_format", err_start);
endtask

task automatic load_store_test();
    word_t base;
    word_t ld_val;
    word_t old8;
    int    err_start;
    err_start = err_count;
    base   = $urandom();
    ld_val = $urandom();
    old8   = $urandom();
    load_reg(5'd1, base);
    load_reg(5'd8, old8);
    drive_instr(i_instr(OP_LW, 5'd1, 5'd7, 16'h8010));
    check_word(data_addr, base + 32'h0000_8010, "lw address");
    check_word(word_t'(data_wen), 32'd0, "data_wen during lw");
    data_load = ld_val;
    drive_instr(i_instr(OP_ADDI, 5'd0, 5'd8, 16'h0055));  // loses the write port
    data_load = ~ld_val;
    check_reg(5'd7, ld_val, "r7 after lw");
    check_reg(5'd8, old8, "r8 after dropped addi");
    drive_instr(i_instr(OP_SW, 5'd1, 5'd7, 16'h0024));
    check_word(data_addr, base + 32'h0000_0024, "sw address");
    check_word(data_store, ld_val, "sw data");
    check_word(word_t'(data_wen), 32'd1, "data_wen for sw");
    idle_cycle();
    check_word(word_t'(data_wen), 32'd0, "data_wen pulse width");
    drive_instr(i_instr(OP_LW, 5'd0, 5'd0, 16'h0004));
    data_load = 32'hdead_beef;
    drive_instr(i_instr(OP_ADDI, 5'd0, 5'd10, 16'h0077));  // keeps the write port
    check_reg(5'd0, 32'd0, "r0 after lw");
    check_reg(5'd10, 32'h0000_0077, "r10 after lw to r0");
    report_test("load_store", err_start);
endtask

task automatic branch_test();
    word_t a;
    int    err_start;
    err_start = err_count;
    a = $urandom();
    load_reg(5'd1, a);
    load_reg(5'd2, a);
    load_reg(5'd3, a ^ 32'h0001_0000);
    check_branch(OP_BEQ, 5'd2, 16'($urandom()), 1'b1, "beq equal");
    check_branch(OP_BEQ, 5'd3, 16'($urandom()), 1'b0, "beq unequal");
    check_branch(OP_BNE, 5'd3, 16'($urandom()), 1'b1, "bne unequal");
    check_branch(OP_BNE, 5'd2, 16'($urandom()), 1'b0, "bne equal");
    report_test("branch", err_start);
endtask

task automatic jump_test();
    logic [25:0] tgt;
    word_t       pc;
    word_t       jr_val;
    int          err_start;
    err_start = err_count;
    tgt = 26'($urandom());
    drive_instr(j_instr(OP_J, tgt));
    check_jump(tgt, "j");
    tgt      = 26'($urandom());
    pc       = $urandom();
    pc_plus4 = pc;
    drive_instr(j_instr(OP_JAL, tgt));
    check_jump(tgt, "jal");
    check_reg(5'd31, pc, "r31 after jal");
    jr_val = $urandom();
    load_reg(5'd9, jr_val);
    drive_instr(r_instr(5'd9, 5'd0, 5'd0, 5'd0, FN_JR));
    check_jump(jr_val[25:0], "jr");
    report_test("jump", err_start);
endtask

`endif

// ==== tb_exe_top.sv ====
module tb_exe_top;
    timeunit 1ns;
    timeprecision 1ps;

    import exe_pkg::*;

    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          DRIVE_DLY    = 2;   // after rising edge
    localparam int          TEST_CYCLES  = 400; // reset plus all tests, rounded up
    localparam int          MAX_CYCLES   = TEST_CYCLES + 200;
    localparam logic [31:0] SEED         = 32'h3c6378cd;

    logic               clk;
    logic               arst_n;
    logic               instr_valid;
    word_t              instr;
    word_t              pc_plus4;
    word_t              data_load;
    word_t              data_addr;
    logic               data_wen;
    word_t              data_store;
    logic               j_valid;
    logic [JADDR_W-1:0] j_addr;
    logic               b_valid;
    logic [IMM_W-1:0]   b_addr;

    int err_count  = 0;
    int test_count = 0;
    int cycle_cnt  = 0;

    exe_top i_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_plus4_i    (pc_plus4),
        .data_load_i   (data_load),
        .data_addr_o   (data_addr),
        .data_wen_o    (data_wen),
        .data_store_o  (data_store),
        .j_valid_o     (j_valid),
        .j_addr_o      (j_addr),
        .b_valid_o     (b_valid),
        .b_addr_o      (b_addr)
    );

    `include "tb_exe_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    ////////////////////
    // timeout
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt == MAX_CYCLES);
        $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////
    // test sequence
    initial begin
        void'($urandom(SEED));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc_plus4    = '0;
        data_load   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        arst_n = 1'b1;

        reset_test();
        i_format_test();
        r_format_test();
        load_store_test();
        branch_test();
        jump_test();

        $display("Summary: %0d tests run, %0d mismatches", test_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
exe_pkg.sv
exe_if.sv
exe_alu.sv
exe_regfile.sv
exe_mem_branch.sv
exe_top.sv
tb_exe_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_exe_top
RTL_TOP   ?= exe_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
